// File: include/stcMod_macros.svh
`ifndef STCMOD_MACROS_SVH
`define STCMOD_MACROS_SVH

// Host bus word address width
`define STC_ADDR_W          13

// System block word offsets
`define SYS_RESET           13'h0000
`define SYS_VERSION         13'h0001
`define SYS_TYPE            13'h0002
`define SYS_REBOOT_ADDR     13'h0003

// Modulator block word offsets
`define STCMOD_CONTROL      13'h0010
`define STCMOD_PNPOLY       13'h0011
`define STCMOD_H0REAL       13'h0012
`define STCMOD_H0IMAG       13'h0013
`define STCMOD_H1REAL       13'h0014
`define STCMOD_H1IMAG       13'h0015
`define STCMOD_H0TAU        13'h0016
`define STCMOD_H1TAU        13'h0017

// Datapath field widths
`define STC_TAP_W           18
`define STC_SAMPLE_W        19  // Two taps summed need one extra bit
`define STC_TAU_W           3   // Only the low bits of a tau register reach the delay line
`define STC_MAX_TAU         7

// Pulse shaping
`define STC_RESET_CYCLES    6
`define STC_REBOOT_DELAY    8

`define STC_MOD_IMAGE       16'h5354  // Image code reported in the type and control words

`endif

// File: logic/stcRegPkg.sv
`include "stcMod_macros.svh"

package stcRegPkg;

    // One host bus cycle, sampled on busClk
    typedef struct packed {
        logic [`STC_ADDR_W-1:0] addr;
        logic [31:0]            dataIn;
        logic                   cs;
        logic [3:0]             byteWrite;  // One strobe per byte lane
    } busReq;

    // Word offsets, used as the opcode of the read and write decoders
    typedef enum logic [`STC_ADDR_W-1:0] {
        addrSysReset      = `SYS_RESET,
        addrSysVersion    = `SYS_VERSION,
        addrSysType       = `SYS_TYPE,
        addrSysRebootAddr = `SYS_REBOOT_ADDR,
        addrControl       = `STCMOD_CONTROL,
        addrPnPoly        = `STCMOD_PNPOLY,
        addrH0Real        = `STCMOD_H0REAL,
        addrH0Imag        = `STCMOD_H0IMAG,
        addrH1Real        = `STCMOD_H1REAL,
        addrH1Imag        = `STCMOD_H1IMAG,
        addrH0Tau         = `STCMOD_H0TAU,
        addrH1Tau         = `STCMOD_H1TAU
    } regAddr;

    typedef struct packed {
        logic [23:0]                   pnPolyTaps;
        logic [4:0]                    pnPolyLength;
        logic signed [`STC_TAP_W-1:0]  h0Real;
        logic signed [`STC_TAP_W-1:0]  h0Imag;
        logic signed [`STC_TAP_W-1:0]  h1Real;
        logic signed [`STC_TAP_W-1:0]  h1Imag;
        logic [7:0]                    h0Tau;
        logic [7:0]                    h1Tau;
        logic                          txEnable;
    } stcRegs;

endpackage

// File: logic/stcModPkg.sv
`include "stcMod_macros.svh"

package stcModPkg;

    // Signs of the two antenna symbols for one slot
    // A set Neg bit stands for a symbol of -1
    typedef struct packed {
        logic ant0Neg;
        logic ant1Neg;
        logic firstSlot;  // Set on the (s0, s1) half of the Alamouti block
    } stcSymbolPair;

    // Combined complex sample leaving the modulator
    typedef struct packed {
        logic signed [`STC_SAMPLE_W-1:0] sampleReal;
        logic signed [`STC_SAMPLE_W-1:0] sampleImag;
        logic                            firstSlot;
        logic                            valid;
    } stcSample;

    // Which half of the symbol pair the encoder is capturing
    typedef enum logic {
        slotFirst  = 1'b0,
        slotSecond = 1'b1
    } slotState;

endpackage

// File: logic/stcModTopRegs.sv
`include "stcMod_macros.svh"

module stcModTopRegs (
    input  logic                busClk,
    input  logic                rs,
    input  stcRegPkg::busReq    bus,
    input  logic [15:0]         versionNumber,
    output logic [31:0]         dataOut,
    output stcRegPkg::stcRegs   regs,
    output logic [23:0]         rebootAddress,
    output logic                reboot,
    output logic                swReset
);

    localparam int ResetCntW = $clog2(`STC_RESET_CYCLES + 1);

    stcRegPkg::regAddr      opAddr;
    logic                   resetHit;
    logic                   rebootHit;
    logic [ResetCntW-1:0]   resetCount;
    logic [`STC_REBOOT_DELAY-1:0] rebootShift;

    // Lane 2 of an 18-bit tap only carries bits 17:16
    function automatic logic [`STC_TAP_W-1:0] mergeTap(
        input logic [`STC_TAP_W-1:0] cur,
        input logic [31:0]           data,
        input logic [3:0]            be
    );
        logic [`STC_TAP_W-1:0] res;
        res = cur;
        if (be[0]) res[7:0] = data[7:0];
        if (be[1]) res[15:8] = data[15:8];
        if (be[2]) res[`STC_TAP_W-1:16] = data[`STC_TAP_W-1:16];
        return res;
    endfunction

    function automatic logic [23:0] merge24(
        input logic [23:0] cur,
        input logic [31:0] data,
        input logic [3:0]  be
    );
        logic [23:0] res;
        res = cur;
        for (int i = 0; i < 3; i++) begin
            if (be[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    assign opAddr    = stcRegPkg::regAddr'(bus.addr);
    assign resetHit  = bus.cs && bus.byteWrite[0] && (opAddr == stcRegPkg::addrSysReset);
    assign rebootHit = bus.cs && bus.byteWrite[2] && (opAddr == stcRegPkg::addrSysRebootAddr);

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            regs          <= '0;
            rebootAddress <= '0;
        end else if (bus.cs) begin
            case (opAddr)
                stcRegPkg::addrSysRebootAddr:
                    rebootAddress <= merge24(rebootAddress, bus.dataIn, bus.byteWrite);
                stcRegPkg::addrControl: begin
                    if (bus.byteWrite[3]) regs.txEnable <= bus.dataIn[31];
                end
                stcRegPkg::addrPnPoly: begin
                    regs.pnPolyTaps <= merge24(regs.pnPolyTaps, bus.dataIn, bus.byteWrite);
                    if (bus.byteWrite[3]) regs.pnPolyLength <= bus.dataIn[28:24];
                end
                stcRegPkg::addrH0Real:
                    regs.h0Real <= mergeTap(regs.h0Real, bus.dataIn, bus.byteWrite);
                stcRegPkg::addrH0Imag:
                    regs.h0Imag <= mergeTap(regs.h0Imag, bus.dataIn, bus.byteWrite);
                stcRegPkg::addrH1Real:
                    regs.h1Real <= mergeTap(regs.h1Real, bus.dataIn, bus.byteWrite);
                stcRegPkg::addrH1Imag:
                    regs.h1Imag <= mergeTap(regs.h1Imag, bus.dataIn, bus.byteWrite);
                stcRegPkg::addrH0Tau: begin
                    if (bus.byteWrite[0]) regs.h0Tau <= bus.dataIn[7:0];
                end
                stcRegPkg::addrH1Tau: begin
                    if (bus.byteWrite[0]) regs.h1Tau <= bus.dataIn[7:0];
                end
                default: ;  // Reset, version and type words hold no storage
            endcase
        end
    end

    // Software reset stays high for a fixed number of cycles after the write
    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            resetCount <= '0;
            swReset    <= 1'b0;
        end else if (resetHit) begin
            resetCount <= ResetCntW'(`STC_RESET_CYCLES - 1);
            swReset    <= 1'b1;
        end else if (resetCount != '0) begin
            resetCount <= resetCount - 1'b1;
        end else begin
            swReset <= 1'b0;
        end
    end

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            rebootShift <= '0;
            reboot      <= 1'b0;
        end else begin
            rebootShift <= {rebootShift[`STC_REBOOT_DELAY-2:0], rebootHit};
            reboot      <= rebootShift[`STC_REBOOT_DELAY-1];  // Lands on the write edge plus the delay
        end
    end

    always_comb begin
        dataOut = 32'b0;
        if (bus.cs) begin
            case (opAddr)
                stcRegPkg::addrSysReset,
                stcRegPkg::addrSysVersion:    dataOut = {versionNumber, 16'b0};
                stcRegPkg::addrSysType,
                stcRegPkg::addrControl:       dataOut = {regs.txEnable, 15'b0, `STC_MOD_IMAGE};
                stcRegPkg::addrSysRebootAddr: dataOut = {8'b0, rebootAddress};
                stcRegPkg::addrPnPoly:        dataOut = {3'b0, regs.pnPolyLength, regs.pnPolyTaps};
                stcRegPkg::addrH0Real:        dataOut = {14'b0, regs.h0Real};
                stcRegPkg::addrH0Imag:        dataOut = {14'b0, regs.h0Imag};
                stcRegPkg::addrH1Real:        dataOut = {14'b0, regs.h1Real};
                stcRegPkg::addrH1Imag:        dataOut = {14'b0, regs.h1Imag};
                stcRegPkg::addrH0Tau:         dataOut = {24'b0, regs.h0Tau};
                stcRegPkg::addrH1Tau:         dataOut = {24'b0, regs.h1Tau};
                default:                      dataOut = 32'b0;
            endcase
        end
    end

endmodule

// File: logic/pnGenerator.sv
module pnGenerator (
    input  logic               busClk,
    input  logic               rs,
    input  logic               swReset,
    input  stcRegPkg::stcRegs  regs,
    output logic               pnBit,
    output logic               pnValid
);

    localparam int LfsrW = $bits(regs.pnPolyTaps);

    logic [LfsrW-1:0] lfsr;
    logic             feedback;

    // The generator runs on every cycle that transmission is enabled
    assign pnValid = regs.txEnable & ~swReset;

    // Every tapped stage feeds the XOR of the Fibonacci form
    assign feedback = ^(lfsr & regs.pnPolyTaps);

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            lfsr <= '1;
        end else if (!pnValid) begin
            lfsr <= '1;  // Reseed so every burst starts from the same point
        end else begin
            lfsr <= {lfsr[LfsrW-2:0], feedback};
        end
    end

    always_comb begin
        // Lengths past the register width read the last stage
        if (regs.pnPolyLength < 5'(LfsrW)) begin
            pnBit = lfsr[regs.pnPolyLength];
        end else begin
            pnBit = lfsr[LfsrW-1];
        end
    end

endmodule

// File: logic/stcEncoder.sv
`include "stcMod_macros.svh"

module stcEncoder (
    input  logic                      busClk,
    input  logic                      rs,
    input  logic                      swReset,
    input  stcRegPkg::stcRegs         regs,
    input  logic                      pnBit,
    input  logic                      pnValid,
    output stcModPkg::stcSymbolPair   pair,
    output logic                      pairValid
);

    localparam int TauW = `STC_TAU_W;
    localparam int Depth = `STC_MAX_TAU;

    stcModPkg::slotState          slot;
    logic                         restart;
    logic                         havePair;   // A full (s0, s1) block is in flight
    logic                         s0Hold;
    logic [1:0]                   flight;     // Bit 1 is s0, bit 0 is s1
    logic [1:0]                   rawNeg;     // Undelayed signs indexed by antenna
    logic                         rawFirst;
    logic                         rawValid;
    logic [1:0][Depth-1:0]        line;
    logic [1:0][TauW-1:0]         tau;
    logic [1:0]                   delNeg;

    assign restart = swReset | ~pnValid;
    assign tau[0]  = regs.h0Tau[TauW-1:0];
    assign tau[1]  = regs.h1Tau[TauW-1:0];

    // s0 waits in s0Hold until s1 completes the block in flight
    always_ff @(posedge busClk) begin
        if (pnValid && slot == stcModPkg::slotFirst) s0Hold <= pnBit;
        if (pnValid && slot == stcModPkg::slotSecond) flight <= {s0Hold, pnBit};
    end

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            slot     <= stcModPkg::slotFirst;
            havePair <= 1'b0;
            rawNeg   <= '0;
            rawFirst <= 1'b0;
            rawValid <= 1'b0;
            line     <= '0;  // Delay lines start out holding +1
        end else if (restart) begin
            slot     <= stcModPkg::slotFirst;
            havePair <= 1'b0;
            rawNeg   <= '0;
            rawFirst <= 1'b0;
            rawValid <= 1'b0;
            line     <= '0;
        end else begin
            rawValid <= havePair;
            if (slot == stcModPkg::slotFirst) begin
                rawNeg   <= {flight[0], flight[1]};  // Antenna 1 gets s1, antenna 0 gets s0
                rawFirst <= 1'b1;
                slot     <= stcModPkg::slotSecond;
            end else begin
                rawNeg   <= {flight[1], ~flight[0]};  // (-s1, s0)
                rawFirst <= 1'b0;
                havePair <= 1'b1;
                slot     <= stcModPkg::slotFirst;
            end
            if (rawValid) begin
                for (int a = 0; a < 2; a++) begin
                    line[a] <= {line[a][Depth-2:0], rawNeg[a]};
                end
            end
        end
    end

    always_comb begin
        for (int a = 0; a < 2; a++) begin
            if (tau[a] == '0) delNeg[a] = rawNeg[a];
            else delNeg[a] = line[a][tau[a] - TauW'(1)];
        end
    end

    assign pair      = '{ant0Neg: delNeg[0], ant1Neg: delNeg[1], firstSlot: rawFirst};
    assign pairValid = rawValid;

endmodule

// File: logic/channelCombiner.sv
`include "stcMod_macros.svh"

module channelCombiner (
    input  logic                     busClk,
    input  logic                     rs,
    input  stcRegPkg::stcRegs        regs,
    input  stcModPkg::stcSymbolPair  pair,
    input  logic                     pairValid,
    output stcModPkg::stcSample      sample
);

    localparam int SampleW = `STC_SAMPLE_W;

    logic signed [SampleW-1:0] sumReal;
    logic signed [SampleW-1:0] sumImag;
    logic signed [SampleW-1:0] realQ;
    logic signed [SampleW-1:0] imagQ;
    logic                      firstQ;
    logic                      validQ;

    // A +-1 symbol times a tap is just the tap with its sign flipped
    function automatic logic signed [SampleW-1:0] weight(
        input logic signed [`STC_TAP_W-1:0] tap,
        input logic                         neg
    );
        logic signed [SampleW-1:0] ext;
        ext = SampleW'(tap);
        return neg ? -ext : ext;
    endfunction

    always_comb begin
        sumReal = weight(regs.h0Real, pair.ant0Neg) + weight(regs.h1Real, pair.ant1Neg);
        sumImag = weight(regs.h0Imag, pair.ant0Neg) + weight(regs.h1Imag, pair.ant1Neg);
    end

    always_ff @(posedge busClk) begin
        realQ  <= sumReal;
        imagQ  <= sumImag;
        firstQ <= pair.firstSlot;
    end

    always_ff @(posedge busClk or posedge rs) begin
        if (rs) validQ <= 1'b0;
        else validQ <= pairValid;
    end

    assign sample = '{sampleReal: realQ, sampleImag: imagQ, firstSlot: firstQ, valid: validQ};

endmodule

// File: logic/stcModTop.sv
module stcModTop (
    input  logic                 busClk,
    input  logic                 rs,
    input  stcRegPkg::busReq     bus,
    input  logic [15:0]          versionNumber,
    output logic [31:0]          dataOut,
    output logic [23:0]          rebootAddress,
    output logic                 reboot,
    output stcModPkg::stcSample  sample
);

    stcRegPkg::stcRegs        regs;
    stcModPkg::stcSymbolPair  pair;
    logic                     swReset;
    logic                     pnBit;
    logic                     pnValid;
    logic                     pairValid;

    stcModTopRegs uRegs (
        .busClk(busClk), .rs(rs), .bus(bus), .versionNumber(versionNumber),
        .dataOut(dataOut), .regs(regs), .rebootAddress(rebootAddress),
        .reboot(reboot), .swReset(swReset)
    );

    pnGenerator uPn (
        .busClk(busClk), .rs(rs), .swReset(swReset), .regs(regs),
        .pnBit(pnBit), .pnValid(pnValid)
    );

    stcEncoder uEnc (
        .busClk(busClk), .rs(rs), .swReset(swReset), .regs(regs),
        .pnBit(pnBit), .pnValid(pnValid), .pair(pair), .pairValid(pairValid)
    );

    channelCombiner uComb (
        .busClk(busClk), .rs(rs), .regs(regs),
        .pair(pair), .pairValid(pairValid), .sample(sample)
    );

endmodule

// File: dv/stcMod_properties.sv
`include "stcMod_macros.svh"

module stcMod_properties (
    input logic                busClk,
    input logic                rs,
    input stcRegPkg::busReq    bus,
    input stcRegPkg::stcRegs   regs,
    input logic                swReset,
    input logic                reboot,
    input stcModPkg::stcSample sample
);
    timeunit 1ns;
    timeprecision 100ps;

    int                failCount = 0;
    stcRegPkg::stcRegs regsQ;
    logic              resetWrite;
    logic              rebootWrite;

    // True when v is one of the four sums of +-a and +-b
    function automatic logic inTapSet(
        input logic signed [`STC_SAMPLE_W-1:0] v,
        input logic signed [`STC_TAP_W-1:0]    a,
        input logic signed [`STC_TAP_W-1:0]    b
    );
        logic signed [`STC_SAMPLE_W-1:0] x;
        logic signed [`STC_SAMPLE_W-1:0] y;
        x = a;
        y = b;
        return (v == x + y) || (v == x - y) || (v == -x + y) || (v == -x - y);
    endfunction

    always_ff @(posedge busClk) regsQ <= regs;  // Settings that built the sample now at the output

    assign resetWrite  = bus.cs && bus.byteWrite[0] && (bus.addr == `SYS_RESET);
    assign rebootWrite = bus.cs && bus.byteWrite[2] && (bus.addr == `SYS_REBOOT_ADDR);

    assert property (@(posedge busClk) rs |-> !sample.valid && !reboot && !swReset)
        else begin failCount++; $error("Outputs not idle during reset"); end

    assert property (@(posedge busClk) disable iff (rs)
        resetWrite |=> swReset [*`STC_RESET_CYCLES] ##1 !swReset)
        else begin failCount++; $error("Software reset pulse has the wrong length"); end

    // The pulse is driven on the write edge plus the delay, seen one sample later
    assert property (@(posedge busClk) disable iff (rs)
        rebootWrite |-> ##(`STC_REBOOT_DELAY + 1) reboot ##1 !reboot)
        else begin failCount++; $error("Reboot pulse misplaced or too long"); end

    assert property (@(posedge busClk) disable iff (rs)
        $rose(regs.txEnable) && !swReset |-> !sample.valid [*4] ##1 sample.valid)
        else begin failCount++; $error("First valid sample not 4 cycles after enable"); end

    assert property (@(posedge busClk) disable iff (rs)
        sample.valid && regs.txEnable && !swReset |=> sample.valid)
        else begin failCount++; $error("Valid stream has a gap"); end

    assert property (@(posedge busClk) disable iff (rs)
        $fell(regs.txEnable) || $rose(swReset) |-> ##2 !sample.valid)
        else begin failCount++; $error("Valid did not drop after disable or reset"); end

    assert property (@(posedge busClk) disable iff (rs)
        sample.valid |-> inTapSet(sample.sampleReal, regsQ.h0Real, regsQ.h1Real)
                      && inTapSet(sample.sampleImag, regsQ.h0Imag, regsQ.h1Imag))
        else begin failCount++; $error("Sample outside the set of tap sums"); end

endmodule

bind stcModTop stcMod_properties uProps (.*);

// File: dv/stcModTb.sv
`include "stcMod_macros.svh"

module stcModTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CycleLimit = 2000;  // About five times the cycles the sequence needs

    logic                busClk;
    logic                rs;
    stcRegPkg::busReq    bus;
    logic [15:0]         versionNumber;
    logic [31:0]         dataOut;
    logic [23:0]         rebootAddress;
    logic                reboot;
    stcModPkg::stcSample sample;

    integer      seed;
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] img [0:31];  // Expected register images, indexed by the low offset bits
    logic signed [`STC_SAMPLE_W-1:0] hist [0:63];
    logic        histFirst [0:63];
    logic [23:0] lfsr;
    logic [12:0] addrs [0:11];
    logic [12:0] a;
    logic [31:0] d;
    logic [3:0]  be;
    logic        s0;
    logic        s1;
    int          tau;

    stcModTop u_dut (.*);

    initial begin
        busClk = 1'b0;
        forever #50 busClk = ~busClk;
    end

    always @(posedge busClk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout: the run passed %0d cycles without finishing", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic checkValue(input string name, input longint exp, input longint act);
        assert (exp == act) else begin
            errors++;
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic logic [31:0] writeMask(input logic [12:0] addr);
        case (addr)
            `SYS_REBOOT_ADDR:                   return 32'h00FF_FFFF;
            `STCMOD_CONTROL:                    return 32'h8000_0000;
            `STCMOD_PNPOLY:                     return 32'h1FFF_FFFF;
            `STCMOD_H0REAL, `STCMOD_H0IMAG,
            `STCMOD_H1REAL, `STCMOD_H1IMAG:     return 32'h0003_FFFF;
            `STCMOD_H0TAU, `STCMOD_H1TAU:       return 32'h0000_00FF;
            default:                            return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] expRead(input logic [12:0] addr);
        case (addr)
            `SYS_RESET, `SYS_VERSION:           return {versionNumber, 16'h0};
            `SYS_TYPE:                          return img[5'h10];
            default:                            return writeMask(addr) != 0 ? img[addr[4:0]] : 0;
        endcase
    endfunction

    task automatic busWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] en);
        logic [31:0] m;
        m = writeMask(addr) & {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
        @(posedge busClk);
        #1;
        bus = '{addr: addr, dataIn: data, cs: 1'b1, byteWrite: en};
        img[addr[4:0]] = (img[addr[4:0]] & ~m) | (data & m);
        @(posedge busClk);
        #1;
        bus.cs = 1'b0;
        bus.byteWrite = 4'h0;
    endtask

    task automatic checkRead(input logic [12:0] addr);
        @(posedge busClk);
        #1;
        bus = '{addr: addr, dataIn: 32'h0, cs: 1'b1, byteWrite: 4'h0};
        #10;
        checkValue("regReadback", expRead(addr), dataOut);
        @(posedge busClk);
        #1;
        bus.cs = 1'b0;
        #10;
        checkValue("readWithoutCs", 0, dataOut);
    endtask

    // Records n consecutive samples once valid shows up
    task automatic collect(input int n);
        @(negedge busClk);
        while (!sample.valid) @(negedge busClk);
        for (int i = 0; i < n; i++) begin
            assert (sample.valid) else begin
                errors++;
                $display("Valid dropped in the middle of the stream");
            end
            hist[i] = sample.sampleReal;
            histFirst[i] = sample.firstSlot;
            @(negedge busClk);
        end
    endtask

    function automatic logic nextPn();
        logic b;
        b = lfsr[img[5'h11][28:24]];
        lfsr = {lfsr[22:0], ^(lfsr & img[5'h11][23:0])};
        return b;
    endfunction

    // With taps 1 and 2 each real value names both antenna signs
    function automatic int realOf(input logic n0, input logic n1);
        return (n0 ? -1 : 1) + (n1 ? -2 : 2);
    endfunction

    function automatic logic neg0(input int v);
        return v == 1 || v == -3;
    endfunction

    function automatic logic neg1(input int v);
        return v < 0;
    endfunction

    task automatic setTaps(input logic [31:0] r0, input logic [31:0] i0,
                           input logic [31:0] r1, input logic [31:0] i1);
        busWrite(`STCMOD_H0REAL, r0, 4'h7);
        busWrite(`STCMOD_H0IMAG, i0, 4'h7);
        busWrite(`STCMOD_H1REAL, r1, 4'h7);
        busWrite(`STCMOD_H1IMAG, i1, 4'h7);
    endtask

    initial begin
        seed = 22;
        versionNumber = 16'h0103;
        bus = '0;
        rs = 1'b1;
        for (int i = 0; i < 32; i++) img[i] = 32'h0;
        img[5'h10] = {16'h0, `STC_MOD_IMAGE};
        addrs = '{`SYS_VERSION, `SYS_TYPE, `SYS_REBOOT_ADDR, `STCMOD_CONTROL, `STCMOD_PNPOLY,
                  `STCMOD_H0REAL, `STCMOD_H0IMAG, `STCMOD_H1REAL, `STCMOD_H1IMAG,
                  `STCMOD_H0TAU, `STCMOD_H1TAU, 13'h0020};
        repeat (16) @(posedge busClk);
        #1 rs = 1'b0;

        // Each write with a random lane mask is read back at once
        for (int i = 0; i < 40; i++) begin
            a = addrs[$unsigned($random(seed)) % 12];
            d = $random(seed);
            be = $random(seed);
            if (a == `STCMOD_CONTROL) d[31] = 1'b0;  // Keep the datapath idle here
            busWrite(a, d, be);
            checkRead(a);
        end
        checkRead(`SYS_RESET);
        checkValue("rebootAddress", img[5'h03][23:0], rebootAddress);

        busWrite(`SYS_RESET, 32'h1, 4'h1);
        busWrite(`SYS_REBOOT_ADDR, 32'h00A5_5A3C, 4'h7);
        repeat (12) @(posedge busClk);
        checkValue("rebootAddress", 24'hA55A3C, rebootAddress);

        busWrite(`STCMOD_PNPOLY, {3'b0, 5'd22, 24'hC00001}, 4'hF);
        setTaps(1, 0, 2, 0);
        busWrite(`STCMOD_H0TAU, 0, 4'h1);
        busWrite(`STCMOD_H1TAU, 0, 4'h1);
        busWrite(`STCMOD_CONTROL, 32'h8000_0000, 4'h8);
        collect(40);
        busWrite(`STCMOD_CONTROL, 0, 4'h8);
        lfsr = '1;
        for (int i = 0; i < 40; i += 2) begin
            s0 = nextPn();
            s1 = nextPn();
            checkValue("firstSlot", 1, histFirst[i]);
            checkValue("secondSlot", 0, histFirst[i + 1]);
            checkValue("pairFirst", realOf(s0, s1), hist[i]);
            checkValue("pairSecond", realOf(~s1, s0), hist[i + 1]);
        end

        // Software reset in the middle of a stream, which then resumes
        busWrite(`STCMOD_CONTROL, 32'h8000_0000, 4'h8);
        collect(4);
        busWrite(`SYS_RESET, 32'h1, 4'h1);
        repeat (10) @(posedge busClk);
        collect(4);
        busWrite(`STCMOD_CONTROL, 0, 4'h8);

        setTaps($random(seed), $random(seed), $random(seed), $random(seed));
        busWrite(`STCMOD_H0TAU, $unsigned($random(seed)) % 8, 4'h1);
        busWrite(`STCMOD_H1TAU, $unsigned($random(seed)) % 8, 4'h1);
        busWrite(`STCMOD_CONTROL, 32'h8000_0000, 4'h8);
        collect(30);
        busWrite(`STCMOD_CONTROL, 0, 4'h8);

        // Antenna 0 delayed, antenna 1 direct
        tau = ($unsigned($random(seed)) % `STC_MAX_TAU) + 1;
        setTaps(1, 0, 2, 0);
        busWrite(`STCMOD_H0TAU, tau, 4'h1);
        busWrite(`STCMOD_H1TAU, 0, 4'h1);
        busWrite(`STCMOD_CONTROL, 32'h8000_0000, 4'h8);
        collect(40);
        busWrite(`STCMOD_CONTROL, 0, 4'h8);
        for (int i = 0; i < 40; i++) begin
            if (i < tau) begin
                checkValue("tauStart", 0, neg0(hist[i]));
            end else if (histFirst[i - tau]) begin
                checkValue("tauDelay", neg1(hist[i - tau + 1]), neg0(hist[i]));
            end else begin
                checkValue("tauDelay", !neg1(hist[i - tau - 1]), neg0(hist[i]));
            end
        end

        repeat (5) @(posedge busClk);
        $display("Value errors: %0d, assertion failures: %0d", errors, u_dut.uProps.failCount);
        if (errors == 0 && u_dut.uProps.failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
logic/stcRegPkg.sv
logic/stcModPkg.sv
logic/stcModTopRegs.sv
logic/pnGenerator.sv
logic/stcEncoder.sv
logic/channelCombiner.sv
logic/stcModTop.sv
dv/stcMod_properties.sv
dv/stcModTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module stcModTb -f filelist.f -o stcModSim 2>&1 | tee build.log

./obj_dir/stcModSim 2>&1 | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
